//--- source/subsys_config.svh
// Region bases compare against address bits 15:12 only, and each CCM window must fit its offset
`ifndef SUBSYS_CONFIG_SVH
`define SUBSYS_CONFIG_SVH

// ===========================================================================
// Bus geometry
// ===========================================================================
`define AHB_ADDR_W   16   // Byte address, 64 KiB space
`define AHB_DATA_W   32

// Word-address bits per memory window (256 words each)
`define CCM_WORDS_W  8

// ===========================================================================
// Region select values of haddr[15:12]
// ===========================================================================
`define DCCM_BASE     4'h0
`define ICCM_BASE     4'h4
`define SOC_IFC_BASE  4'hC

`endif

//--- source/ahb_pkg.sv
// AHB-Lite types for a single-initiator fabric; bursts, protection and locked transfers are absent
`include "subsys_config.svh"

package ahb_pkg;

    // Transfer type, AMBA encoding
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // Only the three sizes up to the bus width
    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    // Same address word, seen by the decoder or by a memory window
    typedef union packed {
        struct packed {
            logic [3:0]                          region;   // Selects the responder
            logic [`AHB_ADDR_W-5:0]              offset;
        } dec;
        struct packed {
            logic [3:0]                          unused;
            logic [`AHB_ADDR_W-`CCM_WORDS_W-7:0] rsvd;     // Above the window, ignored
            logic [`CCM_WORDS_W-1:0]             word_idx;
            logic [1:0]                          byte_off;
        } mem;
    } bus_addr_u;

endpackage

//--- source/subsys_pkg.sv
// Responder indices and register map of the SoC interface block; offsets are word indices

package subsys_pkg;

    // ========================================================================
    // Data-phase responder select
    // ========================================================================
    typedef enum logic [1:0] {
        RESP_DCCM    = 2'd0,
        RESP_ICCM    = 2'd1,
        RESP_SOC_IFC = 2'd2
    } resp_idx_e;

    // ========================================================================
    // SoC interface registers, byte offset is index * 4
    // ========================================================================
    typedef enum logic [2:0] {
        REG_ICCM_LOCK   = 3'd0,   // Set-only lock
        REG_GENERIC_OUT = 3'd1,
        REG_GENERIC_IN  = 3'd2,   // Read only
        REG_INTR_STATUS = 3'd3,   // Write 1 to clear
        REG_INTR_EN     = 3'd4
    } soc_reg_e;

    // Blocked ICCM access, in both status and enable
    localparam int INTR_BLOCKED_BIT = 0;

endpackage

//--- source/ahb_decoder.sv
// Responders must never stall (readyout tied high); errors come only from this decoder
`include "subsys_config.svh"

module ahb_decoder (
    input  logic                     clk,
    input  logic                     rst_i,

    // Initiator side
    input  ahb_pkg::bus_addr_u       haddr_i,
    input  ahb_pkg::htrans_e         htrans_i,
    input  logic                     hwrite_i,
    input  ahb_pkg::hsize_e          hsize_i,
    input  logic [`AHB_DATA_W-1:0]   hwdata_i,
    output logic [`AHB_DATA_W-1:0]   hrdata_o,
    output logic                     hready_o,
    output logic                     hresp_o,

    // ICCM protection
    input  logic                     iccm_lock_i,
    output logic                     iccm_blocked_o,

    // Responder side
    output logic                     ccm_sel_o,
    output logic                     ccm_iccm_o,
    output logic                     soc_sel_o,
    output logic [`AHB_ADDR_W-5:0]   resp_offset_o,
    output logic                     resp_write_o,
    output ahb_pkg::hsize_e          resp_size_o,
    output logic [`AHB_DATA_W-1:0]   resp_wdata_o,
    input  logic [`AHB_DATA_W-1:0]   ccm_rdata_i,
    input  logic                     ccm_ready_i,
    input  logic [`AHB_DATA_W-1:0]   soc_rdata_i,
    input  logic                     soc_ready_i
);
    import ahb_pkg::*;
    import subsys_pkg::*;

    logic      accept;
    logic      hit_dccm;
    logic      hit_iccm;
    logic      hit_soc;
    logic      iccm_denied;
    logic      bad_access;
    logic      dphase_ready;

    logic      dvalid_q;      // A responder owns the data phase
    resp_idx_e dsel_q;
    logic      err_first_q;
    logic      err_second_q;
    logic      blocked_q;

    // ========================================================================
    // Address phase
    // ========================================================================
    assign accept = hready_o && (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

    assign hit_dccm    = (haddr_i.dec.region == `DCCM_BASE);
    assign hit_iccm    = (haddr_i.dec.region == `ICCM_BASE);
    assign hit_soc     = (haddr_i.dec.region == `SOC_IFC_BASE);
    assign iccm_denied = hit_iccm && iccm_lock_i;

    // Unmapped, or ICCM while locked
    assign bad_access = accept && !(hit_dccm || hit_soc || (hit_iccm && !iccm_lock_i));

    assign ccm_sel_o  = accept && (hit_dccm || (hit_iccm && !iccm_lock_i));
    assign ccm_iccm_o = hit_iccm;   // Bank select inside the shared memory
    assign soc_sel_o  = accept && hit_soc;

    assign resp_offset_o = haddr_i.dec.offset;
    assign resp_write_o  = hwrite_i;
    assign resp_size_o   = hsize_i;
    assign resp_wdata_o  = hwdata_i;   // Already data-phase aligned

    // ========================================================================
    // Data phase tracking and error sequence
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dvalid_q     <= 1'b0;
            dsel_q       <= RESP_DCCM;
            err_first_q  <= 1'b0;
            err_second_q <= 1'b0;
            blocked_q    <= 1'b0;
        end else begin
            if (hready_o) begin
                dvalid_q <= ccm_sel_o || soc_sel_o;
                if (soc_sel_o) begin
                    dsel_q <= RESP_SOC_IFC;
                end else if (hit_iccm) begin
                    dsel_q <= RESP_ICCM;
                end else begin
                    dsel_q <= RESP_DCCM;
                end
            end
            err_first_q  <= bad_access;
            err_second_q <= err_first_q;
            blocked_q    <= bad_access && iccm_denied;   // Only in the first error cycle
        end
    end

    // Response mux
    always_comb begin
        hrdata_o     = '0;
        dphase_ready = 1'b1;
        if (dvalid_q) begin
            case (dsel_q)
                RESP_DCCM, RESP_ICCM: begin
                    hrdata_o     = ccm_rdata_i;
                    dphase_ready = ccm_ready_i;
                end
                RESP_SOC_IFC: begin
                    hrdata_o     = soc_rdata_i;
                    dphase_ready = soc_ready_i;
                end
                default: begin
                    hrdata_o     = '0;
                    dphase_ready = 1'b1;
                end
            endcase
        end
    end

    assign hresp_o        = err_first_q || err_second_q;
    assign hready_o       = !err_first_q && dphase_ready;   // Low only in first error cycle
    assign iccm_blocked_o = blocked_q;

endmodule

//--- source/ccm_sram.sv
// One array holds DCCM and ICCM banks; addresses must be naturally aligned for the given size
`include "subsys_config.svh"

module ccm_sram (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     hsel_i,
    input  logic                     iccm_i,
    input  logic [`AHB_ADDR_W-5:0]   offset_i,
    input  logic                     hwrite_i,
    input  ahb_pkg::hsize_e          hsize_i,
    input  logic [`AHB_DATA_W-1:0]   hwdata_i,
    output logic [`AHB_DATA_W-1:0]   hrdata_o,
    output logic                     hreadyout_o
);
    import ahb_pkg::*;

    localparam int LANES = `AHB_DATA_W / 8;
    localparam int DEPTH = 2 * (1 << `CCM_WORDS_W);   // Both windows

    logic [`AHB_DATA_W-1:0] ram [DEPTH];

    bus_addr_u             addr_view;
    logic [LANES-1:0]      lane_en;

    logic                  wr_pend_q;
    logic [LANES-1:0]      lane_en_q;
    logic [`CCM_WORDS_W:0] idx_q;       // {bank, word}

    assign addr_view = `AHB_ADDR_W'(offset_i);

    // Byte lanes covered by the transfer
    always_comb begin
        case (hsize_i)
            HSIZE_BYTE: lane_en = LANES'(1) << addr_view.mem.byte_off;
            HSIZE_HALF: lane_en = LANES'(3) << addr_view.mem.byte_off;
            HSIZE_WORD: lane_en = '1;
            default:    lane_en = '1;
        endcase
    end

    // ========================================================================
    // Address phase capture
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_pend_q <= 1'b0;
        end else begin
            wr_pend_q <= hsel_i && hwrite_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hsel_i) begin
            idx_q     <= {iccm_i, addr_view.mem.word_idx};
            lane_en_q <= lane_en;
        end
    end

    // ========================================================================
    // Data phase
    // ========================================================================
    always_ff @(posedge clk) begin
        if (wr_pend_q) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en_q[i]) begin
                    ram[idx_q][8*i +: 8] <= hwdata_i[8*i +: 8];
                end
            end
        end
    end

    // Read from the registered index, sees a write that landed on the same edge
    assign hrdata_o    = ram[idx_q];
    assign hreadyout_o = 1'b1;   // Zero wait states

endmodule

//--- source/soc_ifc_regs.sv
// Word-only register writes; the ICCM lock can be released only by reset
`include "subsys_config.svh"

module soc_ifc_regs (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     hsel_i,
    input  logic [`AHB_ADDR_W-5:0]   offset_i,
    input  logic                     hwrite_i,
    input  logic [`AHB_DATA_W-1:0]   hwdata_i,
    output logic [`AHB_DATA_W-1:0]   hrdata_o,
    output logic                     hreadyout_o,
    input  logic                     iccm_blocked_i,
    input  logic [`AHB_DATA_W-1:0]   generic_input_i,
    output logic [`AHB_DATA_W-1:0]   generic_output_o,
    output logic                     iccm_lock_o,
    output logic                     irq_o
);
    import subsys_pkg::*;

    localparam int REG_IDX_W = $bits(soc_reg_e);

    logic                   reg_hit;
    soc_reg_e               reg_sel;
    logic                   wr_lock;
    logic                   wr_gen;
    logic                   wr_sts;
    logic                   wr_en;

    logic                   wr_pend_q;
    logic                   hit_q;
    soc_reg_e               reg_q;

    logic                   iccm_lock_q;
    logic [`AHB_DATA_W-1:0] gen_out_q;
    logic                   intr_sts_q;
    logic                   intr_sts_d;
    logic                   intr_en_q;
    logic                   intr_en_d;
    logic                   irq_q;

    // Offsets past the last register read as zero
    assign reg_hit = (offset_i[`AHB_ADDR_W-5:REG_IDX_W+2] == '0);
    assign reg_sel = soc_reg_e'(offset_i[REG_IDX_W+1:2]);

    // ========================================================================
    // Address phase capture
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_pend_q <= 1'b0;
            hit_q     <= 1'b0;
        end else begin
            wr_pend_q <= hsel_i && hwrite_i && reg_hit;
            hit_q     <= hsel_i && reg_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hsel_i) begin
            reg_q <= reg_sel;
        end
    end

    assign wr_lock = wr_pend_q && (reg_q == REG_ICCM_LOCK);
    assign wr_gen  = wr_pend_q && (reg_q == REG_GENERIC_OUT);
    assign wr_sts  = wr_pend_q && (reg_q == REG_INTR_STATUS);
    assign wr_en   = wr_pend_q && (reg_q == REG_INTR_EN);

    // ========================================================================
    // Interrupt next state
    // ========================================================================
    always_comb begin
        intr_en_d  = intr_en_q;
        intr_sts_d = intr_sts_q;
        if (wr_en) begin
            intr_en_d = hwdata_i[INTR_BLOCKED_BIT];
        end
        if (wr_sts && hwdata_i[INTR_BLOCKED_BIT]) begin
            intr_sts_d = 1'b0;
        end
        if (iccm_blocked_i) begin
            intr_sts_d = 1'b1;   // New event beats a clear
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            iccm_lock_q <= 1'b0;
            gen_out_q   <= '0;
            intr_sts_q  <= 1'b0;
            intr_en_q   <= 1'b0;
            irq_q       <= 1'b0;
        end else begin
            if (wr_lock && hwdata_i[0]) begin
                iccm_lock_q <= 1'b1;   // Sticky until reset
            end
            if (wr_gen) begin
                gen_out_q <= hwdata_i;
            end
            intr_sts_q <= intr_sts_d;
            intr_en_q  <= intr_en_d;
            irq_q      <= intr_sts_d && intr_en_d;   // One cycle after the pulse
        end
    end

    // Read mux, data phase
    always_comb begin
        hrdata_o = '0;
        if (hit_q) begin
            case (reg_q)
                REG_ICCM_LOCK:   hrdata_o[0] = iccm_lock_q;
                REG_GENERIC_OUT: hrdata_o = gen_out_q;
                REG_GENERIC_IN:  hrdata_o = generic_input_i;
                REG_INTR_STATUS: hrdata_o[INTR_BLOCKED_BIT] = intr_sts_q;
                REG_INTR_EN:     hrdata_o[INTR_BLOCKED_BIT] = intr_en_q;
                default:         hrdata_o = '0;
            endcase
        end
    end

    assign hreadyout_o      = 1'b1;
    assign generic_output_o = gen_out_q;
    assign iccm_lock_o      = iccm_lock_q;
    assign irq_o            = irq_q;

endmodule

//--- source/subsys_top.sv
// Single AHB-Lite initiator port with one synchronous reset; no wait states except error responses
`include "subsys_config.svh"

module subsys_top (
    input  logic                     clk,
    input  logic                     rst_i,

    // AHB-Lite responder port
    input  ahb_pkg::bus_addr_u       haddr_i,
    input  ahb_pkg::htrans_e         htrans_i,
    input  logic                     hwrite_i,
    input  ahb_pkg::hsize_e          hsize_i,
    input  logic [`AHB_DATA_W-1:0]   hwdata_i,
    output logic [`AHB_DATA_W-1:0]   hrdata_o,
    output logic                     hready_o,
    output logic                     hresp_o,

    // SoC side wires
    input  logic [`AHB_DATA_W-1:0]   generic_input_i,
    output logic [`AHB_DATA_W-1:0]   generic_output_o,
    output logic                     iccm_lock_o,
    output logic                     irq_o
);
    import ahb_pkg::*;

    logic                   ccm_sel;
    logic                   ccm_iccm;
    logic                   soc_sel;
    logic [`AHB_ADDR_W-5:0] resp_offset;
    logic                   resp_write;
    hsize_e                 resp_size;
    logic [`AHB_DATA_W-1:0] resp_wdata;
    logic [`AHB_DATA_W-1:0] ccm_rdata;
    logic                   ccm_ready;
    logic [`AHB_DATA_W-1:0] soc_rdata;
    logic                   soc_ready;
    logic                   iccm_lock;
    logic                   iccm_blocked;

    // ========================================================================
    // Address decoder
    // ========================================================================
    ahb_decoder u_decoder (
        .clk            (clk),
        .rst_i          (rst_i),
        .haddr_i        (haddr_i),
        .htrans_i       (htrans_i),
        .hwrite_i       (hwrite_i),
        .hsize_i        (hsize_i),
        .hwdata_i       (hwdata_i),
        .hrdata_o       (hrdata_o),
        .hready_o       (hready_o),
        .hresp_o        (hresp_o),
        .iccm_lock_i    (iccm_lock),
        .iccm_blocked_o (iccm_blocked),
        .ccm_sel_o      (ccm_sel),
        .ccm_iccm_o     (ccm_iccm),
        .soc_sel_o      (soc_sel),
        .resp_offset_o  (resp_offset),
        .resp_write_o   (resp_write),
        .resp_size_o    (resp_size),
        .resp_wdata_o   (resp_wdata),
        .ccm_rdata_i    (ccm_rdata),
        .ccm_ready_i    (ccm_ready),
        .soc_rdata_i    (soc_rdata),
        .soc_ready_i    (soc_ready)
    );

    // DCCM and ICCM windows share this datapath
    ccm_sram u_ccm (
        .clk         (clk),
        .rst_i       (rst_i),
        .hsel_i      (ccm_sel),
        .iccm_i      (ccm_iccm),
        .offset_i    (resp_offset),
        .hwrite_i    (resp_write),
        .hsize_i     (resp_size),
        .hwdata_i    (resp_wdata),
        .hrdata_o    (ccm_rdata),
        .hreadyout_o (ccm_ready)
    );

    soc_ifc_regs u_soc_ifc (
        .clk              (clk),
        .rst_i            (rst_i),
        .hsel_i           (soc_sel),
        .offset_i         (resp_offset),
        .hwrite_i         (resp_write),
        .hwdata_i         (resp_wdata),
        .hrdata_o         (soc_rdata),
        .hreadyout_o      (soc_ready),
        .iccm_blocked_i   (iccm_blocked),
        .generic_input_i  (generic_input_i),
        .generic_output_o (generic_output_o),
        .iccm_lock_o      (iccm_lock),
        .irq_o            (irq_o)
    );

    assign iccm_lock_o = iccm_lock;

endmodule

//--- bench/tb_subsys_top.sv
// Single transfers only, one idle cycle between them; register accesses are word sized
`include "subsys_config.svh"

module tb_subsys_top;
    timeunit 1ns;
    timeprecision 100ps;

    import ahb_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 16;
    localparam int N_LANE     = 8;
    localparam int N_XFERS    = 4 * N_RAND + 5 * N_LANE + 40;   // Upper bound on transfers

    // SoC interface register addresses
    localparam logic [15:0] ADDR_LOCK    = 16'hC000;
    localparam logic [15:0] ADDR_GEN_OUT = 16'hC004;
    localparam logic [15:0] ADDR_GEN_IN  = 16'hC008;
    localparam logic [15:0] ADDR_STATUS  = 16'hC00C;
    localparam logic [15:0] ADDR_EN      = 16'hC010;

    logic                   clk = 1'b0;
    logic                   rst_i;
    bus_addr_u              haddr;
    htrans_e                htrans;
    logic                   hwrite;
    hsize_e                 hsize;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic [`AHB_DATA_W-1:0] hrdata;
    logic                   hready;
    logic                   hresp;
    logic [`AHB_DATA_W-1:0] generic_input;
    logic [`AHB_DATA_W-1:0] generic_output;
    logic                   iccm_lock;
    logic                   irq;

    // Reference model state
    logic [31:0] mem_m [512];   // {iccm, word index}
    logic        lock_m;
    logic [31:0] gen_out_m;
    logic [31:0] gen_in_m;
    logic        sts_m;
    logic        en_m;

    integer      seed = 32'h8fa7;
    int          pass_cnt = 0;
    int          err_cnt  = 0;

    // Pending comparisons
    logic [31:0] act_q [$];
    logic [31:0] exp_q [$];
    string       msg_q [$];
    event        chk_ev;

    subsys_top u_dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .haddr_i          (haddr),
        .htrans_i         (htrans),
        .hwrite_i         (hwrite),
        .hsize_i          (hsize),
        .hwdata_i         (hwdata),
        .hrdata_o         (hrdata),
        .hready_o         (hready),
        .hresp_o          (hresp),
        .generic_input_i  (generic_input),
        .generic_output_o (generic_output),
        .iccm_lock_o      (iccm_lock),
        .irq_o            (irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic logic [8:0] mem_index(input logic [15:0] addr);
        return {addr[15:12] == `ICCM_BASE, addr[9:2]};   // Bits 11:10 ignored
    endfunction

    function automatic logic expect_error(input logic [15:0] addr);
        logic [3:0] region;
        region = addr[15:12];
        if (region == `DCCM_BASE || region == `SOC_IFC_BASE) begin
            return 1'b0;
        end
        return !(region == `ICCM_BASE && !lock_m);
    endfunction

    function automatic logic [31:0] ref_read(input logic [15:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr[15:12] == `SOC_IFC_BASE) begin
            if (addr[11:5] == '0) begin
                case (addr[4:2])
                    3'd0:    v[0] = lock_m;
                    3'd1:    v = gen_out_m;
                    3'd2:    v = gen_in_m;
                    3'd3:    v[0] = sts_m;
                    3'd4:    v[0] = en_m;
                    default: v = '0;
                endcase
            end
        end else begin
            v = mem_m[mem_index(addr)];
        end
        return v;
    endfunction

    task automatic model_write(input logic [15:0] addr, input hsize_e sz, input logic [31:0] d);
        logic [3:0] lanes;
        logic [8:0] idx;
        if (addr[15:12] == `SOC_IFC_BASE) begin
            case (addr[4:2])
                3'd0: lock_m = lock_m | d[0];   // Set only
                3'd1: gen_out_m = d;
                3'd3: sts_m = sts_m & ~d[0];    // Write 1 to clear
                3'd4: en_m = d[0];
                default: ;
            endcase
        end else begin
            case (sz)
                HSIZE_BYTE: lanes = 4'b0001 << addr[1:0];
                HSIZE_HALF: lanes = 4'b0011 << addr[1:0];
                default:    lanes = 4'b1111;
            endcase
            idx = mem_index(addr);
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    mem_m[idx][8*i +: 8] = d[8*i +: 8];
                end
            end
        end
    endtask

    task automatic model_reset();
        lock_m    = 1'b0;
        gen_out_m = '0;
        sts_m     = 1'b0;
        en_m      = 1'b0;
    endtask

    // ========================================================================
    // Checking
    // ========================================================================
    task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp) begin
            err_cnt++;
            $display("error at %0d ns: %s, got %h expected %h", $time, msg, act, exp);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic queue_check(input logic [31:0] act, input logic [31:0] exp,
                               input string msg);
        act_q.push_back(act);
        exp_q.push_back(exp);
        msg_q.push_back(msg);
        -> chk_ev;
    endtask

    // Comparison process
    always begin
        @(chk_ev);
        while (act_q.size() != 0) begin
            check_eq(act_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
        end
    end

    // ========================================================================
    // AHB driver
    // ========================================================================
    task automatic xfer(input logic [15:0] addr, input logic wr, input hsize_e sz,
                        input logic [31:0] wdata, output logic [31:0] rdata,
                        output logic err, output int n_cyc);
        @(posedge clk);
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hwrite <= wr;
        hsize  <= sz;
        @(negedge clk);
        while (!hready) begin
            @(negedge clk);
        end
        @(posedge clk);                         // Address accepted
        htrans <= HTRANS_IDLE;
        hwdata <= wdata;
        @(negedge clk);
        err   = hresp;
        n_cyc = 1;
        while (!hready) begin                   // Error first cycle
            @(negedge clk);
            err   = err & hresp;
            n_cyc = n_cyc + 1;
        end
        rdata = hrdata;
        @(posedge clk);                         // Data phase ends
    endtask

    task automatic bus_write(input logic [15:0] addr, input hsize_e sz, input logic [31:0] d);
        logic        exp_err;
        logic        err;
        logic [31:0] rd;
        int          n_cyc;
        exp_err = expect_error(addr);
        xfer(addr, 1'b1, sz, d, rd, err, n_cyc);
        queue_check({31'b0, err}, {31'b0, exp_err}, $sformatf("hresp, write %h", addr));
        queue_check(n_cyc, exp_err ? 32'd2 : 32'd1,
                    $sformatf("data phase cycles, write %h", addr));
        if (!exp_err) begin
            model_write(addr, sz, d);
        end else if (addr[15:12] == `ICCM_BASE) begin
            sts_m = 1'b1;                       // Blocked by the lock
        end
    endtask

    task automatic bus_read(input logic [15:0] addr);
        logic        exp_err;
        logic [31:0] exp;
        logic        err;
        logic [31:0] rd;
        int          n_cyc;
        exp_err = expect_error(addr);
        exp     = ref_read(addr);
        xfer(addr, 1'b0, HSIZE_WORD, '0, rd, err, n_cyc);
        queue_check({31'b0, err}, {31'b0, exp_err}, $sformatf("hresp, read %h", addr));
        queue_check(n_cyc, exp_err ? 32'd2 : 32'd1,
                    $sformatf("data phase cycles, read %h", addr));
        if (!exp_err) begin
            queue_check(rd, exp, $sformatf("read data at %h", addr));
        end else if (addr[15:12] == `ICCM_BASE) begin
            sts_m = 1'b1;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_i <= 1'b1;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        model_reset();
    endtask

    task automatic check_idle_outputs();
        @(negedge clk);
        queue_check({31'b0, hready}, 32'd1, "hready_o after reset");
        queue_check({31'b0, hresp}, 32'd0, "hresp_o after reset");
        queue_check({31'b0, iccm_lock}, 32'd0, "iccm_lock_o after reset");
        queue_check({31'b0, irq}, 32'd0, "irq_o after reset");
        queue_check(generic_output, 32'd0, "generic_output_o after reset");
    endtask

    task automatic end_test(input int num, input string name, input int base);
        -> chk_ev;
        @(negedge clk);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (err_cnt == base) ? "pass" : "FAIL", err_cnt - base);
    endtask

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [11:0] rand_word_off();
        logic [31:0] r;
        r = $random(seed);
        return {r[11:2], 2'b00};
    endfunction

    // Watchdog sized from the longest expected run
    initial begin
        #(N_XFERS * 4 * CLK_PERIOD + 2000);
        $display("timeout: the tests did not finish in time, the bus may be stuck");
        $display("Something failed");
        $finish;
    end

    // ========================================================================
    // Tests
    // ========================================================================
    initial begin
        logic [11:0] offs [N_RAND];
        logic [11:0] off;
        logic [31:0] d;
        logic [3:0]  region;
        int          base;

        rst_i         = 1'b1;
        haddr         = '0;
        htrans        = HTRANS_IDLE;
        hwrite        = 1'b0;
        hsize         = HSIZE_WORD;
        hwdata        = '0;
        generic_input = '0;
        gen_in_m      = '0;
        model_reset();
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        check_idle_outputs();

        // 1. Random words in both windows at shared offsets
        base = err_cnt;
        for (int i = 0; i < N_RAND; i++) begin
            offs[i] = rand_word_off();
            bus_write({`DCCM_BASE, offs[i]}, HSIZE_WORD, next_random());
            bus_write({`ICCM_BASE, offs[i]}, HSIZE_WORD, next_random());
        end
        for (int i = 0; i < N_RAND; i++) begin
            bus_read({`DCCM_BASE, offs[i]});
            bus_read({`ICCM_BASE, offs[i]});
        end
        end_test(1, "random words", base);

        // 2. Byte and half-word lanes
        base = err_cnt;
        for (int i = 0; i < N_LANE; i++) begin
            region = (i % 2 == 0) ? `DCCM_BASE : `ICCM_BASE;
            off    = rand_word_off();
            d      = next_random();
            bus_write({region, off}, HSIZE_WORD, next_random());
            bus_write({region, off[11:2], d[1:0]}, HSIZE_BYTE, next_random());
            bus_read({region, off});
            bus_write({region, off[11:2], d[2], 1'b0}, HSIZE_HALF, next_random());
            bus_read({region, off});
        end
        end_test(2, "byte lanes", base);

        // 3. Unmapped regions
        base = err_cnt;
        off  = rand_word_off();
        bus_write({`DCCM_BASE, off}, HSIZE_WORD, next_random());
        bus_write({`ICCM_BASE, off}, HSIZE_WORD, next_random());
        for (int i = 0; i < 3; i++) begin
            region = next_random();
            while (region == `DCCM_BASE || region == `ICCM_BASE ||
                   region == `SOC_IFC_BASE) begin
                region = next_random();
            end
            bus_write({region, off}, HSIZE_WORD, next_random());
            bus_read({region, off});
        end
        bus_read({`DCCM_BASE, off});
        bus_read({`ICCM_BASE, off});
        end_test(3, "unmapped", base);

        // 4. ICCM lock held until reset with ICCM data kept
        base = err_cnt;
        off  = rand_word_off();
        bus_write({`ICCM_BASE, off}, HSIZE_WORD, next_random());
        bus_write(ADDR_LOCK, HSIZE_WORD, 32'd1);
        @(negedge clk);
        queue_check({31'b0, iccm_lock}, 32'd1, "iccm_lock_o after lock");
        bus_read(ADDR_LOCK);
        bus_write({`ICCM_BASE, off}, HSIZE_WORD, next_random());
        bus_read({`ICCM_BASE, off});
        bus_write({`DCCM_BASE, off}, HSIZE_WORD, next_random());
        bus_read({`DCCM_BASE, off});
        apply_reset();
        check_idle_outputs();
        bus_read({`ICCM_BASE, off});
        end_test(4, "iccm lock", base);

        // 5. Blocked-access interrupt and generic wires
        base = err_cnt;
        bus_write(ADDR_EN, HSIZE_WORD, 32'd1);
        bus_write(ADDR_LOCK, HSIZE_WORD, 32'd1);
        @(negedge clk);
        queue_check({31'b0, irq}, 32'd0, "irq_o before blocked access");
        bus_read({`ICCM_BASE, rand_word_off()});
        @(negedge clk);
        queue_check({31'b0, irq}, 32'd1, "irq_o after blocked access");
        bus_read(ADDR_STATUS);
        bus_write(ADDR_STATUS, HSIZE_WORD, 32'd1);
        @(negedge clk);
        queue_check({31'b0, irq}, 32'd0, "irq_o after status clear");
        bus_read(ADDR_STATUS);
        d = next_random();
        bus_write(ADDR_GEN_OUT, HSIZE_WORD, d);
        @(negedge clk);
        queue_check(generic_output, d, "generic_output_o");
        bus_read(ADDR_GEN_OUT);
        gen_in_m = next_random();
        @(posedge clk);
        generic_input <= gen_in_m;
        bus_read(ADDR_GEN_IN);
        end_test(5, "interrupt and generic wires", base);

        $display("checks passed: %0d, checks failed: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/ahb_pkg.sv
source/subsys_pkg.sv
source/ahb_decoder.sv
source/ccm_sram.sv
source/soc_ifc_regs.sv
source/subsys_top.sv
bench/tb_subsys_top.sv
